// ==== common/ls_pkg.sv ====
package ls_pkg;

    // data path and address width.
    localparam int WORD_W = 32;

    // lane count and the width of a lane index.
    localparam int NUM_LANES = 4;
    localparam int LANE_W = 2;

    // destination register tag.
    localparam int TAG_W = 5;

    // scratchpad geometry, in words.
    localparam int MEM_WORDS = 64;
    localparam int MEM_AW = 6;

    typedef logic [WORD_W-1:0] word_t;

    // memory operation carried with each issued instruction.
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } mem_op_t;

    // lane request FSM.
    // DONE covers an access that completes without touching memory.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        WAIT = 2'd1,
        DONE = 2'd2
    } lane_state_t;

endpackage

// ==== ls_lane/fu_scalar_ls.sv ====
`timescale 1ns/1ps

module fu_scalar_ls
    import ls_pkg::*;
(
    input  logic             CLK,
    input  logic             nRST,
    input  logic             start,
    input  mem_op_t          op,
    input  word_t            rs1,
    input  word_t            imm,
    input  word_t            rs2,
    input  logic [TAG_W-1:0] tag,
    input  logic             grant,
    input  logic             dhit,
    input  word_t            dmem_load,
    output logic             free,
    output logic             dmem_ren,
    output logic             dmem_wen,
    output word_t            dmem_addr,
    output word_t            dmem_store,
    output logic             cmpl_valid,
    output logic [TAG_W-1:0] cmpl_tag,
    output word_t            cmpl_data,
    output logic             cmpl_fault
);

    lane_state_t state, next_state;

    word_t addr;
    word_t addr_q, store_q;
    logic [TAG_W-1:0] tag_q;
    mem_op_t op_q;
    logic fault_q;
    logic misaligned;

    assign addr = imm + rs1;
    assign misaligned = (addr[1:0] != 2'b00);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // operands are captured once per start.
    always_ff @(posedge CLK) begin
        if (start && (state == IDLE)) begin
            addr_q  <= addr;
            store_q <= rs2;
            tag_q   <= tag;
            op_q    <= op;
            fault_q <= misaligned;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    // bad address or no-op: skip the memory port entirely.
                    if (misaligned || (op == NONE)) begin
                        next_state = DONE;
                    end else begin
                        next_state = WAIT;
                    end
                end
            end
            WAIT: begin
                if (grant && dhit) begin
                    next_state = IDLE;
                end
            end
            DONE: begin
                if (grant) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    assign free = (state == IDLE);

    // request is held through the dhit cycle.
    assign dmem_ren   = (state == WAIT) && grant && (op_q == LOAD);
    assign dmem_wen   = (state == WAIT) && grant && (op_q == STORE);
    assign dmem_addr  = addr_q;
    assign dmem_store = store_q;

    assign cmpl_valid = grant && (((state == WAIT) && dhit) || (state == DONE));
    assign cmpl_tag   = tag_q;
    assign cmpl_data  = (op_q == LOAD) ? dmem_load : '0;
    assign cmpl_fault = (state == DONE) && fault_q;

    a_ren_wen_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(dmem_ren && dmem_wen));

    // the arbiter must keep the grant until this lane sees dhit.
    a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        (dmem_ren || dmem_wen) && !dhit |=> (dmem_ren || dmem_wen) && $stable(dmem_addr));

endmodule

// ==== verilog/ls_dispatch.sv ====
`timescale 1ns/1ps

module ls_dispatch
    import ls_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 issue_valid,
    input  mem_op_t              issue_op,
    input  word_t                issue_rs1,
    input  word_t                issue_imm,
    input  word_t                issue_rs2,
    input  logic [TAG_W-1:0]     issue_tag,
    input  logic [NUM_LANES-1:0] lane_free,
    output logic                 issue_ready,
    output logic [NUM_LANES-1:0] lane_start,
    output mem_op_t              op_out,
    output word_t                rs1_out,
    output word_t                imm_out,
    output word_t                rs2_out,
    output logic [TAG_W-1:0]     tag_out
);

    logic [LANE_W-1:0] tail_q;
    logic run_q;
    logic accept;

    // run_q holds off issue until the first edge out of reset.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tail_q <= '0;
            run_q  <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (accept) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    assign issue_ready = run_q && lane_free[tail_q];
    assign accept = issue_valid && issue_ready;

    always_comb begin
        lane_start = '0;
        if (accept) begin
            lane_start[tail_q] = 1'b1;
        end
    end

    // op fields are shared, only the started lane latches them.
    assign op_out  = issue_op;
    assign rs1_out = issue_rs1;
    assign imm_out = issue_imm;
    assign rs2_out = issue_rs2;
    assign tag_out = issue_tag;

    a_start_free: assert property (@(posedge CLK) disable iff (!nRST)
        (lane_start & ~lane_free) == '0);

endmodule

// ==== verilog/ls_arbiter.sv ====
`timescale 1ns/1ps

module ls_arbiter
    import ls_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [NUM_LANES-1:0] lane_ren,
    input  logic [NUM_LANES-1:0] lane_wen,
    input  word_t                lane_addr [NUM_LANES],
    input  word_t                lane_store [NUM_LANES],
    input  logic [NUM_LANES-1:0] lane_cmpl_valid,
    input  logic [TAG_W-1:0]     lane_cmpl_tag [NUM_LANES],
    input  word_t                lane_cmpl_data [NUM_LANES],
    input  logic [NUM_LANES-1:0] lane_cmpl_fault,
    input  logic                 mem_dhit,
    input  word_t                mem_load,
    output logic [NUM_LANES-1:0] grant,
    output logic [NUM_LANES-1:0] lane_dhit,
    output word_t                lane_load,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output logic [MEM_AW-1:0]    mem_addr,
    output word_t                mem_store,
    output logic                 cmpl_valid,
    output logic [TAG_W-1:0]     cmpl_tag,
    output word_t                cmpl_data,
    output logic                 cmpl_fault
);

    logic [LANE_W-1:0] head_q;

    // head follows the dispatch ring, one lane at a time.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            head_q <= '0;
        end else if (lane_cmpl_valid[head_q]) begin
            head_q <= head_q + 1'b1;
        end
    end

    always_comb begin
        grant = '0;
        grant[head_q] = 1'b1;
        lane_dhit = '0;
        lane_dhit[head_q] = mem_dhit;
    end

    assign lane_load = mem_load;

    // byte address to word index.
    assign mem_ren   = lane_ren[head_q];
    assign mem_wen   = lane_wen[head_q];
    assign mem_addr  = lane_addr[head_q][MEM_AW+1:2];
    assign mem_store = lane_store[head_q];

    assign cmpl_valid = lane_cmpl_valid[head_q];
    assign cmpl_tag   = lane_cmpl_tag[head_q];
    assign cmpl_data  = lane_cmpl_data[head_q];
    assign cmpl_fault = lane_cmpl_fault[head_q];

    a_grant_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot(grant));

    a_cmpl_granted: assert property (@(posedge CLK) disable iff (!nRST)
        (lane_cmpl_valid & ~grant) == '0);

endmodule

// ==== verilog/ls_scratchpad.sv ====
`timescale 1ns/1ps

module ls_scratchpad
    import ls_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic              ren,
    input  logic              wen,
    input  logic [MEM_AW-1:0] addr,
    input  word_t             wdata,
    output logic              dhit,
    output word_t             rdata
);

    word_t mem [MEM_WORDS];

    logic [7:0] lfsr_q;
    logic [1:0] cnt_q;
    logic busy_q;
    logic req;

    assign req = ren || wen;

    // x^8 + x^6 + x^5 + x^4 + 1, runs every cycle.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lfsr_q <= 8'hA5;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    // wait of 1 to 4 cycles is picked when a request first shows up.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!busy_q && req) begin
            busy_q <= 1'b1;
            cnt_q  <= lfsr_q[1:0];
        end else if (dhit) begin
            busy_q <= 1'b0;
        end else if (busy_q && (cnt_q != 2'd0)) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign dhit = busy_q && req && (cnt_q == 2'd0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (dhit && wen) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

endmodule

// ==== verilog/ls_cluster_top.sv ====
`timescale 1ns/1ps

module ls_cluster_top
    import ls_pkg::*;
(
    input  logic             CLK,
    input  logic             nRST,
    input  logic             issue_valid,
    input  mem_op_t          issue_op,
    input  word_t            issue_rs1,
    input  word_t            issue_imm,
    input  word_t            issue_rs2,
    input  logic [TAG_W-1:0] issue_tag,
    output logic             issue_ready,
    output logic             cmpl_valid,
    output logic [TAG_W-1:0] cmpl_tag,
    output word_t            cmpl_data,
    output logic             cmpl_fault
);

    logic [NUM_LANES-1:0] lane_free, lane_start, grant, lane_dhit;
    logic [NUM_LANES-1:0] lane_ren, lane_wen, lane_cmpl_valid, lane_cmpl_fault;
    word_t lane_addr [NUM_LANES];
    word_t lane_store [NUM_LANES];
    word_t lane_cmpl_data [NUM_LANES];
    logic [TAG_W-1:0] lane_cmpl_tag [NUM_LANES];

    mem_op_t op_d;
    word_t rs1_d, imm_d, rs2_d;
    logic [TAG_W-1:0] tag_d;
    word_t lane_load;

    logic mem_ren, mem_wen, mem_dhit;
    logic [MEM_AW-1:0] mem_addr;
    word_t mem_store, mem_load;

    ls_dispatch i_dispatch (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_imm   (issue_imm),
        .issue_rs2   (issue_rs2),
        .issue_tag   (issue_tag),
        .lane_free   (lane_free),
        .issue_ready (issue_ready),
        .lane_start  (lane_start),
        .op_out      (op_d),
        .rs1_out     (rs1_d),
        .imm_out     (imm_d),
        .rs2_out     (rs2_d),
        .tag_out     (tag_d)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        fu_scalar_ls i_lane (
            .CLK        (CLK),
            .nRST       (nRST),
            .start      (lane_start[i]),
            .op         (op_d),
            .rs1        (rs1_d),
            .imm        (imm_d),
            .rs2        (rs2_d),
            .tag        (tag_d),
            .grant      (grant[i]),
            .dhit       (lane_dhit[i]),
            .dmem_load  (lane_load),
            .free       (lane_free[i]),
            .dmem_ren   (lane_ren[i]),
            .dmem_wen   (lane_wen[i]),
            .dmem_addr  (lane_addr[i]),
            .dmem_store (lane_store[i]),
            .cmpl_valid (lane_cmpl_valid[i]),
            .cmpl_tag   (lane_cmpl_tag[i]),
            .cmpl_data  (lane_cmpl_data[i]),
            .cmpl_fault (lane_cmpl_fault[i])
        );
    end

    ls_arbiter i_arbiter (
        .CLK             (CLK),
        .nRST            (nRST),
        .lane_ren        (lane_ren),
        .lane_wen        (lane_wen),
        .lane_addr       (lane_addr),
        .lane_store      (lane_store),
        .lane_cmpl_valid (lane_cmpl_valid),
        .lane_cmpl_tag   (lane_cmpl_tag),
        .lane_cmpl_data  (lane_cmpl_data),
        .lane_cmpl_fault (lane_cmpl_fault),
        .mem_dhit        (mem_dhit),
        .mem_load        (mem_load),
        .grant           (grant),
        .lane_dhit       (lane_dhit),
        .lane_load       (lane_load),
        .mem_ren         (mem_ren),
        .mem_wen         (mem_wen),
        .mem_addr        (mem_addr),
        .mem_store       (mem_store),
        .cmpl_valid      (cmpl_valid),
        .cmpl_tag        (cmpl_tag),
        .cmpl_data       (cmpl_data),
        .cmpl_fault      (cmpl_fault)
    );

    ls_scratchpad i_scratchpad (
        .CLK   (CLK),
        .nRST  (nRST),
        .ren   (mem_ren),
        .wen   (mem_wen),
        .addr  (mem_addr),
        .wdata (mem_store),
        .dhit  (mem_dhit),
        .rdata (mem_load)
    );

endmodule

// ==== testbench/ls_checker.sv ====
`timescale 1ns/1ps

module ls_checker
    import ls_pkg::*;
#(
    parameter int NUM_ENTRIES = 1,
    parameter int ENTRY_W = 144
)(
    input  logic               CLK,
    input  logic               nRST,
    input  logic               issue_valid,
    input  logic               issue_ready,
    input  logic               cmpl_valid,
    input  logic [TAG_W-1:0]   cmpl_tag,
    input  word_t              cmpl_data,
    input  logic               cmpl_fault,
    input  logic [ENTRY_W-1:0] golden [NUM_ENTRIES],
    output int                 value_errs,
    output int                 ready_errs,
    output int                 extra_errs,
    output int                 cmpl_count
);

    int n_value = 0;
    int n_ready = 0;
    int n_extra = 0;
    int n_cmpl = 0;
    int n_issued = 0;
    logic out_of_reset;
    logic exp_ready;
    logic [ENTRY_W-1:0] exp_entry;

    assign value_errs = n_value;
    assign ready_errs = n_ready;
    assign extra_errs = n_extra;
    assign cmpl_count = n_cmpl;

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h, got %h (operation %0d, time %0t)",
                     name, expected, actual, n_cmpl, $time);
            n_value++;
        end
    endtask

    // issue opens on the first edge after reset is released.
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    // completions are stable in the middle of the cycle.
    always @(negedge CLK) begin
        if (nRST) begin
            // a lane is free again in the cycle after its completion.
            exp_ready = out_of_reset && ((n_issued - n_cmpl) < NUM_LANES);
            if (issue_ready !== exp_ready) begin
                $display("** Error: issue_ready expected %h, got %h (%0d in flight, time %0t)",
                         exp_ready, issue_ready, n_issued - n_cmpl, $time);
                n_ready++;
            end
            if (issue_valid && issue_ready) begin
                n_issued++;
            end
        end
        if (nRST && cmpl_valid) begin
            if (n_cmpl >= NUM_ENTRIES) begin
                $display("unexpected completion with tag %h after all %0d operations completed",
                         cmpl_tag, NUM_ENTRIES);
                n_extra++;
            end else begin
                exp_entry = golden[n_cmpl];
                check_value("cmpl_tag", word_t'(exp_entry[40:36]), word_t'(cmpl_tag));
                check_value("cmpl_fault", word_t'(exp_entry[0]), word_t'(cmpl_fault));
                // data of a faulted access is not defined.
                if (!exp_entry[0]) begin
                    check_value("cmpl_data", exp_entry[35:4], cmpl_data);
                end
            end
            n_cmpl++;
        end
    end

endmodule

// ==== testbench/tb_ls_cluster.sv ====
`timescale 1ns/1ps

module tb_ls_cluster
    import ls_pkg::*;
();

    localparam int NUM_ENTRIES = 26;
    localparam int ENTRY_W = 144;
    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_ENTRY = 200;
    localparam int DRAIN_LIMIT = 100;
    localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_ENTRIES * CYCLES_PER_ENTRY) * 2 * HALF_PERIOD;

    logic CLK = 1'b0;
    logic nRST;
    logic issue_valid;
    mem_op_t issue_op;
    word_t issue_rs1, issue_imm, issue_rs2;
    logic [TAG_W-1:0] issue_tag;
    logic issue_ready;
    logic cmpl_valid;
    logic [TAG_W-1:0] cmpl_tag;
    word_t cmpl_data;
    logic cmpl_fault;

    logic [ENTRY_W-1:0] golden [NUM_ENTRIES];
    int value_errs, ready_errs, extra_errs, cmpl_count;
    integer seed;

    always #(HALF_PERIOD) CLK = ~CLK;

    ls_cluster_top i_dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_imm   (issue_imm),
        .issue_rs2   (issue_rs2),
        .issue_tag   (issue_tag),
        .issue_ready (issue_ready),
        .cmpl_valid  (cmpl_valid),
        .cmpl_tag    (cmpl_tag),
        .cmpl_data   (cmpl_data),
        .cmpl_fault  (cmpl_fault)
    );

    ls_checker #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .ENTRY_W     (ENTRY_W)
    ) i_checker (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .cmpl_valid  (cmpl_valid),
        .cmpl_tag    (cmpl_tag),
        .cmpl_data   (cmpl_data),
        .cmpl_fault  (cmpl_fault),
        .golden      (golden),
        .value_errs  (value_errs),
        .ready_errs  (ready_errs),
        .extra_errs  (extra_errs),
        .cmpl_count  (cmpl_count)
    );

    // called just after a rising edge and returns just after the accepting edge.
    task automatic drive_entry(input int idx);
        logic [ENTRY_W-1:0] e;
        logic ready_seen;
        e = golden[idx];
        issue_valid = 1'b1;
        issue_op    = mem_op_t'(e[141:140]);
        issue_rs1   = e[139:108];
        issue_imm   = e[107:76];
        issue_rs2   = e[75:44];
        issue_tag   = e[40:36];
        ready_seen  = 1'b0;
        while (!ready_seen) begin
            @(negedge CLK);
            ready_seen = issue_ready;
            @(posedge CLK);
            #2;
        end
        issue_valid = 1'b0;
    endtask

    initial begin
        int gap;
        int drain_cycles;
        int count_errs;
        seed        = 32'ha940_98f9;
        count_errs  = 0;
        nRST        = 1'b0;
        issue_valid = 1'b0;
        issue_op    = NONE;
        issue_rs1   = '0;
        issue_imm   = '0;
        issue_rs2   = '0;
        issue_tag   = '0;
        $readmemh("testbench/ls_golden.txt", golden);
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        nRST = 1'b1;
        @(posedge CLK);
        #2;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            // bit 143 marks an operation issued with no idle cycle before it.
            if (!golden[i][143]) begin
                gap = $random(seed) & 32'h3;
                repeat (gap) begin
                    @(posedge CLK);
                    #2;
                end
            end
            drive_entry(i);
        end
        drain_cycles = 0;
        while ((cmpl_count < NUM_ENTRIES) && (drain_cycles < DRAIN_LIMIT)) begin
            @(posedge CLK);
            drain_cycles++;
        end
        // a few more cycles to catch a duplicated completion.
        repeat (8) @(posedge CLK);
        if (cmpl_count < NUM_ENTRIES) begin
            $display("only %0d of %0d issued operations completed", cmpl_count, NUM_ENTRIES);
            count_errs++;
        end
        $display("errors: value %0d, ready %0d, extra %0d, missing %0d, completions %0d of %0d",
                 value_errs, ready_errs, extra_errs, count_errs, cmpl_count, NUM_ENTRIES);
        if ((value_errs == 0) && (ready_errs == 0) && (extra_errs == 0) &&
            (count_errs == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("errors: value %0d, ready %0d, extra %0d, completions %0d of %0d",
                 value_errs, ready_errs, extra_errs, cmpl_count, NUM_ENTRIES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== testbench/ls_golden.txt ====
// op (1 load, 2 store, +8 no idle gap) _ rs1 _ imm _ rs2 _ tag _ expected data _ fault
// expected data is zero for stores and unchecked on a fault
2_00000010_00000000_11111111_00_00000000_0
2_00000020_00000004_22222222_01_00000000_0
2_00000030_fffffffc_33333333_02_00000000_0
2_00000000_00000040_44444444_03_00000000_0
2_00000080_0000007c_deadbeef_04_00000000_0
1_00000008_00000008_00000000_05_11111111_0
1_00000024_00000000_00000000_06_22222222_0
1_00000028_00000004_00000000_07_33333333_0
1_00000040_00000000_00000000_08_44444444_0
1_000000f0_0000000c_00000000_09_deadbeef_0
1_00000050_00000000_00000000_0a_00000000_0
2_0000005c_00000004_cafef00d_0b_00000000_0
9_00000060_00000000_00000000_0c_cafef00d_0
2_00000070_00000002_badbad00_0d_00000000_1
1_00000070_00000000_00000000_0e_00000000_0
2_00000024_00000001_ffffffff_0f_00000000_1
1_00000024_00000000_00000000_10_22222222_0
2_00000080_00000000_01234567_11_00000000_0
a_00000080_00000004_89abcdef_12_00000000_0
9_00000080_00000000_00000000_13_01234567_0
9_00000084_00000000_00000000_14_89abcdef_0
a_00000008_00000008_55aa55aa_15_00000000_0
9_00000010_00000000_00000000_16_55aa55aa_0
9_000000fc_00000000_00000000_17_deadbeef_0
9_00000024_00000000_00000000_18_22222222_0
9_00000040_00000000_00000000_19_44444444_0

// ==== filelist.f ====
common/ls_pkg.sv
ls_lane/fu_scalar_ls.sv
verilog/ls_dispatch.sv
verilog/ls_arbiter.sv
verilog/ls_scratchpad.sv
verilog/ls_cluster_top.sv
testbench/ls_checker.sv
testbench/tb_ls_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the load/store cluster testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ls_cluster -f filelist.f \
    -Mdir obj_dir -o sim_ls_cluster
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ls_cluster)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
